// ==== cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire                     clk,
    input  wire                     proc_reset,
    input  wire                     proc_read,
    input  wire                     proc_write,
    input  cache_pkg::proc_addr_t   proc_addr,
    input  wire                     hit,
    input  wire                     victim_dirty,
    input  cache_pkg::tag_t         victim_tag,
    input  cache_pkg::line_t        line_data,
    input  wire                     blk_done,
    input  cache_pkg::line_t        blk_rdata,
    output logic                    proc_stall,
    output logic                    fill_en,
    output cache_pkg::line_t        fill_data,
    output logic                    blk_read,
    output logic                    blk_write,
    output cache_pkg::blk_addr_t    blk_addr,
    output cache_pkg::line_t        blk_wdata
);

    cache_pkg::ctrl_state_e state;
    cache_pkg::ctrl_state_e state_next;

    logic                 request;
    cache_pkg::index_t    index;
    cache_pkg::blk_addr_t req_blk_addr;
    cache_pkg::blk_addr_t victim_blk_addr;

    assign request = proc_read | proc_write;
    assign index   = proc_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];

    // block of the request, and the block the victim came from
    assign req_blk_addr    = proc_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];
    assign victim_blk_addr = {victim_tag, index};

    // stall anything that is not a hit in idle
    assign proc_stall = request && !((state == cache_pkg::ctrl_idle) && hit);

    // fetched block goes straight into the store
    assign fill_data = blk_rdata;

    always_comb begin
        state_next = state;
        blk_read   = 1'b0;
        blk_write  = 1'b0;
        blk_addr   = req_blk_addr;
        blk_wdata  = line_data;
        fill_en    = 1'b0;

        case (state)
            cache_pkg::ctrl_idle: begin
                if (request && !hit) begin
                    if (victim_dirty) begin
                        // dirty victim leaves first
                        blk_write  = 1'b1;
                        blk_addr   = victim_blk_addr;
                        state_next = cache_pkg::ctrl_write_back;
                    end else begin
                        blk_read   = 1'b1;
                        state_next = cache_pkg::ctrl_fetch;
                    end
                end
            end

            cache_pkg::ctrl_write_back: begin
                // bridge is idle again in the done cycle
                if (blk_done) begin
                    blk_read   = 1'b1;
                    state_next = cache_pkg::ctrl_fetch;
                end
            end

            cache_pkg::ctrl_fetch: begin
                if (blk_done) begin
                    // line written at this edge, the request hits next cycle
                    fill_en    = 1'b1;
                    state_next = cache_pkg::ctrl_idle;
                end
            end

            default: begin
                state_next = cache_pkg::ctrl_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state <= cache_pkg::ctrl_idle;
        end else begin
            state <= state_next;
        end
    end

    // write-back and fetch are separate bridge requests
    a_one_blk_req: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(blk_read && blk_write)
    ) else $error("cache_ctrl: blk_read and blk_write high together");

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // processor side geometry
    localparam int ADDR_W = 30;
    localparam int WORD_W = 32;

    // cache geometry, eight direct-mapped lines of four words
    localparam int LINE_W   = 128;
    localparam int N_LINES  = 8;
    localparam int INDEX_W  = 3;
    localparam int OFFSET_W = 2;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // memory side block address is tag then index
    localparam int BLK_ADDR_W = TAG_W + INDEX_W;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [ADDR_W-1:0]     proc_addr_t;
    typedef logic [BLK_ADDR_W-1:0] blk_addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [OFFSET_W-1:0]   offset_t;

    // miss handling sequence of the controller
    typedef enum logic [1:0] {
        ctrl_idle       = 2'd0,
        ctrl_write_back = 2'd1,
        ctrl_fetch      = 2'd2
    } ctrl_state_e;

    // one outstanding block request in the bridge
    typedef enum logic [1:0] {
        br_idle  = 2'd0,
        br_write = 2'd1,
        br_read  = 2'd2
    } bridge_state_e;

endpackage

`default_nettype wire

// ==== cache_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_store (
    input  wire                     clk,
    input  wire                     proc_reset,
    input  cache_pkg::proc_addr_t   proc_addr,
    input  wire                     proc_write,
    input  cache_pkg::word_t        proc_wdata,
    input  wire                     fill_en,
    input  cache_pkg::line_t        fill_data,
    output logic                    hit,
    output logic                    victim_dirty,
    output cache_pkg::tag_t         victim_tag,
    output cache_pkg::line_t        line_data,
    output cache_pkg::word_t        rdata_word
);

    // per-line state bits
    logic [cache_pkg::N_LINES-1:0] valid_q;
    logic [cache_pkg::N_LINES-1:0] dirty_q;

    // tag and data arrays
    cache_pkg::tag_t  tag_mem  [cache_pkg::N_LINES];
    cache_pkg::line_t data_mem [cache_pkg::N_LINES];

    cache_pkg::tag_t    req_tag;
    cache_pkg::index_t  index;
    cache_pkg::offset_t offset;
    logic               write_hit;

    // split the word address into tag, index and word offset
    assign req_tag = proc_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
    assign index   = proc_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
    assign offset  = proc_addr[cache_pkg::OFFSET_W-1:0];

    // resident line at the addressed index
    assign victim_tag   = tag_mem[index];
    assign line_data    = data_mem[index];
    assign victim_dirty = valid_q[index] & dirty_q[index];

    // only a valid line can hit
    assign hit = valid_q[index] && (tag_mem[index] == req_tag);

    // word select within the line
    assign rdata_word = line_data[offset*cache_pkg::WORD_W +: cache_pkg::WORD_W];

    assign write_hit = proc_write & hit;

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            // refilled line is always clean
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (write_hit) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index]  <= req_tag;
            data_mem[index] <= fill_data;
        end else if (write_hit) begin
            // merge one word, the rest of the line stays
            data_mem[index][offset*cache_pkg::WORD_W +: cache_pkg::WORD_W] <= proc_wdata;
        end
    end

    // a fill only happens for a block that missed
    a_fill_not_hit: assert property (
        @(posedge clk) disable iff (proc_reset)
        fill_en |-> !hit
    ) else $error("cache_store: fill_en while the addressed line hits");

endmodule

`default_nettype wire

// ==== cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire                     clk,
    input  wire                     proc_reset,
    input  wire                     proc_read,
    input  wire                     proc_write,
    input  cache_pkg::proc_addr_t   proc_addr,
    input  cache_pkg::word_t        proc_wdata,
    output logic                    proc_stall,
    output cache_pkg::word_t        proc_rdata,
    output logic                    mem_read,
    output logic                    mem_write,
    output cache_pkg::blk_addr_t    mem_addr,
    output cache_pkg::line_t        mem_wdata,
    input  cache_pkg::line_t        mem_rdata,
    input  wire                     mem_ready
);

    // store to controller
    logic             hit;
    logic             victim_dirty;
    cache_pkg::tag_t  victim_tag;
    cache_pkg::line_t line_data;

    // controller to store
    logic             fill_en;
    cache_pkg::line_t fill_data;

    // controller to bridge
    logic                 blk_read;
    logic                 blk_write;
    cache_pkg::blk_addr_t blk_addr;
    cache_pkg::line_t     blk_wdata;
    logic                 blk_done;
    cache_pkg::line_t     blk_rdata;

    cache_store u_store (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_addr    (proc_addr),
        .proc_write   (proc_write),
        .proc_wdata   (proc_wdata),
        .fill_en      (fill_en),
        .fill_data    (fill_data),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .line_data    (line_data),
        .rdata_word   (proc_rdata)
    );

    cache_ctrl u_ctrl (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .proc_addr    (proc_addr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .line_data    (line_data),
        .blk_done     (blk_done),
        .blk_rdata    (blk_rdata),
        .proc_stall   (proc_stall),
        .fill_en      (fill_en),
        .fill_data    (fill_data),
        .blk_read     (blk_read),
        .blk_write    (blk_write),
        .blk_addr     (blk_addr),
        .blk_wdata    (blk_wdata)
    );

    mem_bridge u_bridge (
        .clk        (clk),
        .proc_reset (proc_reset),
        .blk_read   (blk_read),
        .blk_write  (blk_write),
        .blk_addr   (blk_addr),
        .blk_wdata  (blk_wdata),
        .blk_done   (blk_done),
        .blk_rdata  (blk_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== mem_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_bridge (
    input  wire                     clk,
    input  wire                     proc_reset,
    input  wire                     blk_read,
    input  wire                     blk_write,
    input  cache_pkg::blk_addr_t    blk_addr,
    input  cache_pkg::line_t        blk_wdata,
    output logic                    blk_done,
    output cache_pkg::line_t        blk_rdata,
    output logic                    mem_read,
    output logic                    mem_write,
    output cache_pkg::blk_addr_t    mem_addr,
    output cache_pkg::line_t        mem_wdata,
    input  wire                     mem_ready,
    input  cache_pkg::line_t        mem_rdata
);

    cache_pkg::bridge_state_e state;

    cache_pkg::blk_addr_t addr_q;
    cache_pkg::line_t     wdata_q;
    cache_pkg::line_t     rdata_q;
    logic                 done_q;

    // memory strobes are decoded from the state register
    assign mem_read  = (state == cache_pkg::br_read);
    assign mem_write = (state == cache_pkg::br_write);
    assign mem_addr  = addr_q;
    assign mem_wdata = wdata_q;

    assign blk_done  = done_q;
    assign blk_rdata = rdata_q;

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state  <= cache_pkg::br_idle;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                cache_pkg::br_idle: begin
                    if (blk_write) begin
                        state <= cache_pkg::br_write;
                    end else if (blk_read) begin
                        state <= cache_pkg::br_read;
                    end
                end
                cache_pkg::br_write, cache_pkg::br_read: begin
                    // hold the request until memory answers
                    if (mem_ready) begin
                        state  <= cache_pkg::br_idle;
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    state <= cache_pkg::br_idle;
                end
            endcase
        end
    end

    // request payload and returned block
    always_ff @(posedge clk) begin
        if ((state == cache_pkg::br_idle) && (blk_read || blk_write)) begin
            addr_q  <= blk_addr;
            wdata_q <= blk_wdata;
        end
        if ((state == cache_pkg::br_read) && mem_ready) begin
            rdata_q <= mem_rdata;
        end
    end

    // controller must wait for blk_done before the next request
    a_req_in_idle: assert property (
        @(posedge clk) disable iff (proc_reset)
        (blk_read || blk_write) |-> (state == cache_pkg::br_idle)
    ) else $error("mem_bridge: block request while one is outstanding");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cache -f sim.f -o tb_cache
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0

// ==== sim.f ====
cache_pkg.sv
cache_store.sv
cache_ctrl.sv
mem_bridge.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv

// ==== tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int N_DIRECTED      = 14;
    localparam int N_RANDOM        = 200;
    localparam int OP_LIMIT        = 64;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * (N_DIRECTED + N_RANDOM);

    // four tags over all indices force conflicts
    localparam cache_pkg::tag_t TAGS [4] = '{25'h0000000, 25'h0000013, 25'h1ab5c00, 25'h0f0f0f1};

    logic                  clk;
    logic                  proc_reset;
    logic                  proc_read;
    logic                  proc_write;
    cache_pkg::proc_addr_t proc_addr;
    cache_pkg::word_t      proc_wdata;
    logic                  proc_stall;
    cache_pkg::word_t      proc_rdata;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_ready;
    cache_pkg::blk_addr_t  mem_addr;
    cache_pkg::line_t      mem_wdata;
    cache_pkg::line_t      mem_rdata;

    // shadow words and expected residency per index
    cache_pkg::word_t              shadow [cache_pkg::proc_addr_t];
    cache_pkg::tag_t               ref_tag [cache_pkg::N_LINES];
    logic [cache_pkg::N_LINES-1:0] ref_valid;
    logic [cache_pkg::N_LINES-1:0] ref_dirty;

    // victim that the request in flight has to write back
    logic                 wb_expected;
    cache_pkg::blk_addr_t wb_addr;

    int          errors;
    int          base_errors;
    int          tests_failed;
    int          mem_reads;
    int          mem_writes;
    int          count_before;
    logic [31:0] rng_state;
    logic [31:0] rnd;

    cache_top DUT (.*);
    tb_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // untouched words hold a pattern of their full word address
    function automatic cache_pkg::word_t expected_word(input cache_pkg::proc_addr_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return ({2'b00, addr} * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic cache_pkg::proc_addr_t make_addr(input logic [1:0] tag_sel,
            input cache_pkg::index_t idx, input cache_pkg::offset_t off);
        return {TAGS[tag_sel], idx, off};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
            input logic [31:0] act_v);
        $display("ERR t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
        errors = errors + 1;
    endtask

    task automatic report_failure(input string what);
        $display("at %0t: %s", $time, what);
        errors = errors + 1;
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == base_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - base_errors);
            tests_failed = tests_failed + 1;
        end
        base_errors = errors;
    endtask

    a_mem_exclusive: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
        else report_failure("mem_read and mem_write high together");

    a_mem_held: assert property (@(posedge clk) disable iff (proc_reset)
        ((mem_read || mem_write) && !mem_ready) |=> ($stable(mem_read) && $stable(mem_write)))
        else report_failure("memory request dropped before mem_ready");

    a_mem_released: assert property (@(posedge clk) disable iff (proc_reset)
        ((mem_read || mem_write) && mem_ready) |=> !(mem_read || mem_write))
        else report_failure("memory request still high after mem_ready");

    // every completed write-back checked word by word
    always @(posedge clk) begin : mem_monitor
        int w;
        if (!proc_reset && mem_ready && mem_read) begin
            mem_reads = mem_reads + 1;
        end
        if (!proc_reset && mem_ready && mem_write) begin
            mem_writes = mem_writes + 1;
            assert (wb_expected) else report_failure("write-back with no dirty victim");
            assert (mem_addr == wb_addr)
                else report_mismatch("mem_addr", 32'(wb_addr), 32'(mem_addr));
            for (w = 0; w < 4; w++) begin
                assert (mem_wdata[w*32 +: 32] == expected_word({wb_addr, w[1:0]}))
                    else report_mismatch($sformatf("mem_wdata[%0d]", w),
                        expected_word({wb_addr, w[1:0]}), mem_wdata[w*32 +: 32]);
            end
        end
    end

    // one processor request from drive to completion
    task automatic run_op(input logic wr, input cache_pkg::proc_addr_t addr,
            input cache_pkg::word_t wdata);
        cache_pkg::tag_t   tag;
        cache_pkg::index_t idx;
        logic              hit_due;
        logic              wb_due;
        int                writes_before;
        int                stalls;
        cache_pkg::word_t  got;
        tag           = addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
        idx           = addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
        hit_due       = ref_valid[idx] && (ref_tag[idx] == tag);
        wb_due        = !hit_due && ref_valid[idx] && ref_dirty[idx];
        wb_expected   = wb_due;
        wb_addr       = {ref_tag[idx], idx};
        writes_before = mem_writes;
        proc_read     = !wr;
        proc_write    = wr;
        proc_addr     = addr;
        proc_wdata    = wdata;
        stalls        = 0;
        // outputs are settled mid-cycle
        @(negedge clk);
        while (proc_stall && stalls < OP_LIMIT) begin
            @(negedge clk);
            stalls = stalls + 1;
        end
        got = proc_rdata;
        assert (!proc_stall) else report_failure("request still stalled after the cycle limit");
        assert (!hit_due || stalls == 0) else report_mismatch("proc_stall cycles", 0, stalls);
        if (!wr) begin
            assert (got == expected_word(addr))
                else report_mismatch("proc_rdata", expected_word(addr), got);
        end
        @(posedge clk);
        #1;
        proc_read   = 1'b0;
        proc_write  = 1'b0;
        wb_expected = 1'b0;
        assert (mem_writes - writes_before == (wb_due ? 1 : 0))
            else report_mismatch("write-back count", wb_due ? 1 : 0, mem_writes - writes_before);
        // a miss leaves the new line clean
        if (!hit_due) begin
            ref_tag[idx]   = tag;
            ref_valid[idx] = 1'b1;
            ref_dirty[idx] = 1'b0;
        end
        if (wr) begin
            shadow[addr]   = wdata;
            ref_dirty[idx] = 1'b1;
        end
    endtask

    initial begin
        errors       = 0;
        base_errors  = 0;
        tests_failed = 0;
        mem_reads    = 0;
        mem_writes   = 0;
        count_before = 0;
        ref_valid    = '0;
        ref_dirty    = '0;
        wb_expected  = 1'b0;
        wb_addr      = '0;
        rng_state    = 32'hc797;
        rnd          = '0;
        proc_reset   = 1'b1;
        proc_read    = 1'b0;
        proc_write   = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        proc_reset = 1'b0;

        @(negedge clk);
        assert (!proc_stall) else report_mismatch("proc_stall", 0, 32'(proc_stall));
        assert (!mem_read && !mem_write) else report_failure("memory request after reset");
        @(posedge clk);
        #1;
        run_op(1'b0, make_addr(2'd0, 3'd0, 2'd0), '0);
        run_op(1'b0, make_addr(2'd1, 3'd3, 2'd2), '0);
        run_op(1'b0, make_addr(2'd2, 3'd7, 2'd1), '0);
        run_op(1'b0, make_addr(2'd3, 3'd4, 2'd3), '0);
        report_test(1, "reads of untouched words");

        run_op(1'b0, make_addr(2'd1, 3'd2, 2'd1), '0);
        count_before = mem_reads;
        run_op(1'b0, make_addr(2'd1, 3'd2, 2'd1), '0);
        run_op(1'b0, make_addr(2'd1, 3'd2, 2'd1), '0);
        assert (mem_reads == count_before)
            else report_mismatch("mem_read count", count_before, mem_reads);
        report_test(2, "repeated read hits");

        run_op(1'b1, make_addr(2'd1, 3'd2, 2'd3), 32'hcafe_0123);
        run_op(1'b0, make_addr(2'd1, 3'd2, 2'd3), '0);
        run_op(1'b1, make_addr(2'd2, 3'd6, 2'd0), 32'h1357_9bdf);
        run_op(1'b0, make_addr(2'd2, 3'd6, 2'd0), '0);
        report_test(3, "write then read");

        // write miss, conflicting write, then read back the evicted word
        count_before = mem_writes;
        run_op(1'b1, make_addr(2'd0, 3'd5, 2'd2), 32'h0bad_f00d);
        run_op(1'b1, make_addr(2'd1, 3'd5, 2'd1), 32'h7e57_a11e);
        run_op(1'b0, make_addr(2'd0, 3'd5, 2'd2), '0);
        assert (mem_writes - count_before == 2)
            else report_mismatch("write-back count", 2, mem_writes - count_before);
        report_test(4, "dirty line eviction");

        repeat (N_RANDOM) begin
            rng_state = xorshift32(rng_state);
            rnd       = rng_state;
            rng_state = xorshift32(rng_state);
            run_op(rnd[0], make_addr(rnd[2:1], rnd[5:3], rnd[7:6]), rng_state);
        end
        report_test(5, "random mixed traffic");

        $display("tests run: 5, failed: %0d, errors: %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  wire                   clk,
    input  wire                   proc_reset,
    input  wire                   mem_read,
    input  wire                   mem_write,
    input  cache_pkg::blk_addr_t  mem_addr,
    input  cache_pkg::line_t      mem_wdata,
    output logic                  mem_ready,
    output cache_pkg::line_t      mem_rdata
);

    // written-back blocks, all others still hold their pattern
    cache_pkg::line_t blocks [cache_pkg::blk_addr_t];

    logic [31:0] rng_state;
    int          wait_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic cache_pkg::line_t block_contents(input cache_pkg::blk_addr_t blk);
        cache_pkg::line_t   blk_line;
        cache_pkg::proc_addr_t word_addr;
        int                 w;
        if (blocks.exists(blk)) begin
            return blocks[blk];
        end
        // every word depends on its full word address
        for (w = 0; w < 4; w++) begin
            word_addr = {blk, w[1:0]};
            blk_line[w*32 +: 32] = ({2'b00, word_addr} * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
        end
        return blk_line;
    endfunction

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        rng_state = 32'hc797;
        wait_cnt  = 0;
        forever begin
            @(posedge clk);
            #1;
            if (proc_reset) begin
                mem_ready = 1'b0;
                wait_cnt  = 0;
            end else if (mem_ready) begin
                // bridge took the answer at this edge
                mem_ready = 1'b0;
            end else if (wait_cnt > 0) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    if (mem_write) begin
                        blocks[mem_addr] = mem_wdata;
                    end else begin
                        mem_rdata = block_contents(mem_addr);
                    end
                    mem_ready = 1'b1;
                end
            end else if (mem_read || mem_write) begin
                // new request, answer after 1 to 4 cycles
                rng_state = xorshift32(rng_state);
                wait_cnt  = 1 + int'(rng_state[1:0]);
            end
        end
    end

endmodule

`default_nettype wire
